/* source/cp0_defines.svh */
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH
`default_nettype none

`define CP0_BADVADDR  5'd8                 // last faulting address
`define CP0_COUNT     5'd9                 // free running counter
`define CP0_COMPARE   5'd11                // timer match value
`define CP0_STATUS    5'd12
`define CP0_CAUSE     5'd13
`define CP0_EPC       5'd14                // return address

`define EXC_VECTOR    32'hBFC00380         // general exception entry

`define ST_IE         0                    // global interrupt enable
`define ST_EXL        1                    // exception level
`define ST_IM_LO      8                    // interrupt mask, 8 bits up
`define CA_BD         31                   // fault in branch delay slot
`define CA_IP_LO      8                    // pending lines, 8 bits up
`define CA_EXC_LO     2                    // exception code, 5 bits up

`default_nettype wire
`endif

/* source/cp0Pkg.sv */
`default_nettype none

package cp0Pkg;

    // cause.ExcCode values
    typedef enum logic [4:0]
    {
        EXC_INT  = 5'd0,                   // external or timer interrupt
        EXC_ADEL = 5'd4,                   // address error, load or fetch
        EXC_ADES = 5'd5,                   // address error, store
        EXC_SYS  = 5'd8,                   // syscall instruction
        EXC_BP   = 5'd9,                   // break instruction
        EXC_RI   = 5'd10,                  // reserved opcode
        EXC_OV   = 5'd12                   // arithmetic overflow
    } excCodeT;

    // trap sequencer states
    typedef enum logic [1:0]
    {
        IDLE   = 2'd0,                     // accepting instructions
        TRAP   = 2'd1,                     // redirect to vector, commit
        RETURN = 2'd2                      // redirect to epc, clear exl
    } ctrlStateT;

endpackage

`default_nettype wire

/* source/excDetect.sv */
`timescale 1ns/1ns
`include "cp0_defines.svh"
`default_nettype none

module excDetect (
    input  logic            instrValid,    // instruction present this cycle
    input  logic [31:0]     pc,
    input  logic            isEret,
    input  logic            syscall,
    input  logic            brk,
    input  logic            reserved,      // undecodable opcode
    input  logic            overflowError,
    input  logic            addressError,  // data access misaligned
    input  logic            memWrite,      // data access is a store
    input  logic [31:0]     errorAddr,     // faulting data address
    input  logic [31:0]     status,
    input  logic [31:0]     cause,
    input  logic [31:0]     epc,
    output logic            takeTrap,
    output cp0Pkg::excCodeT excCode,
    output logic [31:0]     badAddr,
    output logic            setBadAddr
);
    import cp0Pkg::*;

    logic intPending;                      // masked, enabled interrupt
    logic pcMisaligned;
    logic eretFault;                       // eret to misaligned epc
    logic fetchFault;
    logic anyFault;

    assign intPending = (|(cause[`CA_IP_LO +: 8] & status[`ST_IM_LO +: 8]))
                        && status[`ST_IE] && !status[`ST_EXL];

    assign pcMisaligned = (pc[1:0] != 2'b00);
    assign eretFault    = isEret && (epc[1:0] != 2'b00);
    assign fetchFault   = pcMisaligned || eretFault;

    assign anyFault = intPending || fetchFault || reserved || overflowError
                      || syscall || brk || addressError;

    assign takeTrap = instrValid && anyFault;   // also overrides an eret

    // fixed priority, highest first
    always_comb
    begin
        if (intPending)
            excCode = EXC_INT;
        else if (fetchFault)
            excCode = EXC_ADEL;
        else if (reserved)
            excCode = EXC_RI;
        else if (overflowError)
            excCode = EXC_OV;
        else if (syscall)
            excCode = EXC_SYS;
        else if (brk)
            excCode = EXC_BP;
        else if (addressError && memWrite)
            excCode = EXC_ADES;            // store side
        else
            excCode = EXC_INT;             // load side below, else unused
        if (!intPending && !fetchFault && !reserved && !overflowError
            && !syscall && !brk && addressError && !memWrite)
            excCode = EXC_ADEL;
    end

    // own pc wins, then the eret target, then the data address
    assign badAddr = pcMisaligned ? pc : (eretFault ? epc : errorAddr);

    assign setBadAddr = takeTrap && ((excCode == EXC_ADEL) || (excCode == EXC_ADES));

endmodule

`default_nettype wire

/* source/cp0Timer.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0Timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        countWe,           // mtc0 to count
    input  logic        compareWe,         // mtc0 to compare
    input  logic [31:0] wrData,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timerInt           // feeds cause.IP[7]
);

    logic armed;                           // compare written since reset

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count    <= '0;
            compare  <= '0;
            timerInt <= 1'b0;
            armed    <= 1'b0;
        end
        else
        begin
            if (countWe)
                count <= wrData;           // write replaces the increment
            else
                count <= count + 32'd1;
            if (compareWe)
            begin
                compare  <= wrData;
                timerInt <= 1'b0;          // compare write acknowledges
                armed    <= 1'b1;
            end
            else if (armed && (count == compare))
                timerInt <= 1'b1;          // sticky until next compare write
        end
    end

endmodule

`default_nettype wire

/* source/cp0Regs.sv */
`timescale 1ns/1ns
`include "cp0_defines.svh"
`default_nettype none

module cp0Regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              wbCyc,
    input  logic              wbStb,
    input  logic              wbWe,
    input  logic [4:0]        wbAdr,       // cp0 register number
    input  logic [31:0]       wbDatW,
    output logic [31:0]       wbDatR,
    output logic              wbAck,
    input  cp0Pkg::ctrlStateT state,       // commit happens on leaving trap/return
    input  logic [31:0]       epcNext,
    input  logic              bdNext,
    input  cp0Pkg::excCodeT   codeNext,
    input  logic [31:0]       badNext,
    input  logic              writeBad,
    input  logic [4:0]        hwInt,       // level lines, IP[6:2]
    input  logic              timerInt,
    input  logic [31:0]       count,
    input  logic [31:0]       compare,
    output logic [31:0]       status,
    output logic [31:0]       cause,
    output logic [31:0]       epc,
    output logic              countWe,
    output logic              compareWe,
    output logic [31:0]       wrData
);
    import cp0Pkg::*;

    logic        wbReq;                    // strobe not yet acked
    logic        wbWrite;
    logic [7:0]  imReg;
    logic        exlReg;
    logic        ieReg;
    logic        bdReg;
    logic [1:0]  swIntReg;                 // software interrupts IP[1:0]
    excCodeT     codeReg;
    logic [31:0] epcReg;
    logic [31:0] badReg;

    assign wbReq     = wbCyc && wbStb && !wbAck;
    assign wbWrite   = wbReq && wbWe;      // lands on the ack edge
    assign countWe   = wbWrite && (wbAdr == `CP0_COUNT);
    assign compareWe = wbWrite && (wbAdr == `CP0_COMPARE);
    assign wrData    = wbDatW;

    always_ff @(posedge clk)
    begin
        if (rst)
            wbAck <= 1'b0;
        else
            wbAck <= wbReq;                // single cycle ack
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            imReg    <= '0;
            exlReg   <= 1'b0;
            ieReg    <= 1'b0;
            bdReg    <= 1'b0;
            swIntReg <= '0;
            codeReg  <= EXC_INT;
            epcReg   <= '0;
            badReg   <= '0;
        end
        else
        begin
            if (wbWrite)
            begin
                case (wbAdr)
                    `CP0_STATUS:
                    begin
                        imReg  <= wbDatW[`ST_IM_LO +: 8];
                        exlReg <= wbDatW[`ST_EXL];
                        ieReg  <= wbDatW[`ST_IE];
                    end
                    `CP0_CAUSE: swIntReg <= wbDatW[`CA_IP_LO +: 2];   // only sw bits
                    `CP0_EPC:   epcReg   <= wbDatW;
                    default: ;             // badvaddr read only, timer elsewhere
                endcase
            end
            // commit below overrides a same-edge bus write
            if (state == TRAP)
            begin
                codeReg <= codeNext;
                if (writeBad)
                    badReg <= badNext;
                if (!exlReg)
                begin
                    epcReg <= epcNext;     // keep first epc when nested
                    bdReg  <= bdNext;
                end
                exlReg <= 1'b1;
            end
            else if (state == RETURN)
                exlReg <= 1'b0;
        end
    end

    always_comb
    begin
        status = '0;
        status[`ST_IM_LO +: 8] = imReg;
        status[`ST_EXL]        = exlReg;
        status[`ST_IE]         = ieReg;
        cause = '0;
        cause[`CA_BD]          = bdReg;
        cause[`CA_IP_LO +: 8]  = {timerInt, hwInt, swIntReg};   // hw lines live
        cause[`CA_EXC_LO +: 5] = codeReg;
    end

    assign epc = epcReg;

    // held stable by the master through the ack cycle
    always_comb
    begin
        case (wbAdr)
            `CP0_BADVADDR: wbDatR = badReg;
            `CP0_COUNT:    wbDatR = count;
            `CP0_COMPARE:  wbDatR = compare;
            `CP0_STATUS:   wbDatR = status;
            `CP0_CAUSE:    wbDatR = cause;
            `CP0_EPC:      wbDatR = epcReg;
            default:       wbDatR = '0;    // unmapped
        endcase
    end

endmodule

`default_nettype wire

/* source/excControl.sv */
`timescale 1ns/1ns
`include "cp0_defines.svh"
`default_nettype none

module excControl (
    input  logic              clk,
    input  logic              rst,
    input  logic              instrValid,
    input  logic              isEret,
    input  logic              inDelaySlot,
    input  logic [31:0]       pc,
    input  logic              takeTrap,
    input  cp0Pkg::excCodeT   excCode,
    input  logic [31:0]       badAddr,
    input  logic              setBadAddr,
    input  logic [31:0]       epc,
    output cp0Pkg::ctrlStateT state,
    output logic              redirect,    // one cycle after the fault
    output logic              flush,
    output logic [31:0]       newPc,
    output logic [31:0]       epcNext,
    output logic              bdNext,
    output cp0Pkg::excCodeT   codeNext,
    output logic [31:0]       badNext,
    output logic              writeBad
);
    import cp0Pkg::*;

    logic        trapEntry;
    logic        eretEntry;
    logic [31:0] retPc;                    // eret target, sampled on entry

    // pipeline is flushed outside idle, so instrValid is dropped there
    assign trapEntry = (state == IDLE) && instrValid && takeTrap;
    assign eretEntry = (state == IDLE) && instrValid && isEret && !takeTrap;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else if (trapEntry)
            state <= TRAP;
        else if (eretEntry)
            state <= RETURN;
        else
            state <= IDLE;                 // trap and return last one cycle
    end

    always_ff @(posedge clk)
    begin
        if (trapEntry || eretEntry)
        begin
            epcNext  <= inDelaySlot ? (pc - 32'd4) : pc;   // back to the branch
            bdNext   <= inDelaySlot;
            codeNext <= excCode;
            badNext  <= badAddr;
            writeBad <= setBadAddr;
            retPc    <= epc;
        end
    end

    assign redirect = (state != IDLE);
    assign flush    = redirect;
    assign newPc    = (state == RETURN) ? retPc : `EXC_VECTOR;

endmodule

`default_nettype wire

/* source/cp0Top.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0Top (
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  logic [31:0] pc,
    input  logic        inDelaySlot,
    input  logic        isEret,
    input  logic        syscall,
    input  logic        brk,
    input  logic        reserved,
    input  logic        overflowError,
    input  logic        addressError,
    input  logic        memWrite,
    input  logic [31:0] errorAddr,
    input  logic [4:0]  hwInt,
    output logic        redirect,
    output logic [31:0] newPc,
    output logic        flush,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [4:0]  wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic        wbAck
);
    import cp0Pkg::*;

    logic        takeTrap;                 // detect to control
    excCodeT     excCode;
    logic [31:0] badAddr;
    logic        setBadAddr;
    ctrlStateT   state;                    // control to regs
    logic [31:0] epcNext;
    logic        bdNext;
    excCodeT     codeNext;
    logic [31:0] badNext;
    logic        writeBad;
    logic [31:0] status;                   // regs to detect
    logic [31:0] cause;
    logic [31:0] epc;
    logic        countWe;                  // regs to timer
    logic        compareWe;
    logic [31:0] wrData;
    logic [31:0] count;                    // timer to regs
    logic [31:0] compare;
    logic        timerInt;

    excDetect i_excDetect (
        .instrValid(instrValid), .pc(pc), .isEret(isEret), .syscall(syscall),
        .brk(brk), .reserved(reserved), .overflowError(overflowError),
        .addressError(addressError), .memWrite(memWrite), .errorAddr(errorAddr),
        .status(status), .cause(cause), .epc(epc), .takeTrap(takeTrap),
        .excCode(excCode), .badAddr(badAddr), .setBadAddr(setBadAddr)
    );

    cp0Timer i_cp0Timer (
        .clk(clk), .rst(rst), .countWe(countWe), .compareWe(compareWe),
        .wrData(wrData), .count(count), .compare(compare), .timerInt(timerInt)
    );

    cp0Regs i_cp0Regs (
        .clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .state(state), .epcNext(epcNext), .bdNext(bdNext), .codeNext(codeNext),
        .badNext(badNext), .writeBad(writeBad), .hwInt(hwInt), .timerInt(timerInt),
        .count(count), .compare(compare), .status(status), .cause(cause), .epc(epc),
        .countWe(countWe), .compareWe(compareWe), .wrData(wrData)
    );

    excControl i_excControl (
        .clk(clk), .rst(rst), .instrValid(instrValid), .isEret(isEret),
        .inDelaySlot(inDelaySlot), .pc(pc), .takeTrap(takeTrap), .excCode(excCode),
        .badAddr(badAddr), .setBadAddr(setBadAddr), .epc(epc), .state(state),
        .redirect(redirect), .flush(flush), .newPc(newPc), .epcNext(epcNext),
        .bdNext(bdNext), .codeNext(codeNext), .badNext(badNext), .writeBad(writeBad)
    );

endmodule

`default_nettype wire

/* bench/cp0Bench.sv */
`timescale 1ns/1ns
`include "cp0_defines.svh"
`default_nettype none

module cp0Bench;
    import cp0Pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int OP_COUNT      = 150;    // bus accesses plus instructions rounded up
    localparam int CYCLES_PER_OP = 200;

    logic        clk;
    logic        rst;
    logic        instrValid;
    logic [31:0] pc;
    logic        inDelaySlot;
    logic        isEret;
    logic        syscall;
    logic        brk;
    logic        reserved;
    logic        overflowError;
    logic        addressError;
    logic        memWrite;
    logic [31:0] errorAddr;
    logic [4:0]  hwInt;
    logic        redirect;
    logic [31:0] newPc;
    logic        flush;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [4:0]  wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic        wbAck;

    logic [7:0]  mIm;                      // expected register fields
    logic        mExl;
    logic        mIe;
    logic        mBd;
    logic [1:0]  mSw;
    logic [4:0]  mCode;
    logic [31:0] mEpc;
    logic [31:0] mBad;
    logic        mTimer;

    int     errors;
    int     checks;
    integer seed;

    cp0Top i_cp0Top (
        .clk(clk), .rst(rst), .instrValid(instrValid), .pc(pc), .inDelaySlot(inDelaySlot),
        .isEret(isEret), .syscall(syscall), .brk(brk), .reserved(reserved),
        .overflowError(overflowError), .addressError(addressError), .memWrite(memWrite),
        .errorAddr(errorAddr), .hwInt(hwInt), .redirect(redirect), .newPc(newPc),
        .flush(flush), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hard stop if anything stalls
    initial
    begin
        #(OP_COUNT * CYCLES_PER_OP * CLK_PERIOD);
        $display("ERROR: watchdog expired before the test sequence finished");
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] expStatus();
        return {16'd0, mIm, 6'd0, mExl, mIe};
    endfunction

    function automatic logic [31:0] expCause();
        return {mBd, 15'd0, mTimer, hwInt, mSw, 1'b0, mCode, 2'd0};   // IP lines live
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic clearFlags();
        inDelaySlot   = 1'b0;
        isEret        = 1'b0;
        syscall       = 1'b0;
        brk           = 1'b0;
        reserved      = 1'b0;
        overflowError = 1'b0;
        addressError  = 1'b0;
        memWrite      = 1'b0;
        errorAddr     = '0;
    endtask

    // classic cycle held until ack
    task automatic busAccess(input logic we, input logic [4:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd);
        int waitCount;
        rd        = '0;
        waitCount = 0;
        @(posedge clk);
        #1;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = dat;
        @(posedge clk);
        #1;
        while (!wbAck && waitCount < 16)
        begin
            @(posedge clk);
            #1;
            waitCount++;
        end
        if (wbAck)
            rd = wbDatR;                   // valid while ack high
        else
        begin
            errors++;
            $display("ERROR: no Wishbone ack for register %0d", adr);
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic busWrite(input logic [4:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        busAccess(1'b1, adr, dat, ignored);
    endtask

    task automatic checkReg(input string name, input logic [4:0] adr, input logic [31:0] exp);
        logic [31:0] rd;
        busAccess(1'b0, adr, '0, rd);
        checkVal(name, exp, rd);
    endtask

    task automatic checkModel(input string name);
        checkReg({name, " status"}, `CP0_STATUS, expStatus());
        checkReg({name, " cause"}, `CP0_CAUSE, expCause());
        checkReg({name, " epc"}, `CP0_EPC, mEpc);
        checkReg({name, " badvaddr"}, `CP0_BADVADDR, mBad);
    endtask

    task automatic setStatus(input logic [31:0] val);
        busWrite(`CP0_STATUS, val);
        mIm  = val[15:8];
        mExl = val[1];
        mIe  = val[0];
    endtask

    task automatic setCause(input logic [31:0] val);
        busWrite(`CP0_CAUSE, val);
        mSw = val[9:8];                    // sw interrupt bits only
    endtask

    task automatic setEpc(input logic [31:0] val);
        busWrite(`CP0_EPC, val);
        mEpc = val;
    endtask

    // one instruction then redirect timing checks
    task automatic runInstr(input string name, input logic expRedirect, input logic [31:0] expPc);
        int gap;
        @(posedge clk);
        #1;
        instrValid = 1'b1;
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        clearFlags();
        if (expRedirect && !redirect)
        begin
            errors++;
            $display("ERROR: %s: redirect did not come when due", name);
        end
        else if (!expRedirect)
            checkVal({name, " redirect"}, 32'd0, {31'd0, redirect});
        if (expRedirect)
            checkVal({name, " newPc"}, expPc, newPc);
        checkVal({name, " flush"}, {31'd0, expRedirect}, {31'd0, flush});
        @(posedge clk);
        #1;
        checkVal({name, " redirect width"}, 32'd0, {31'd0, redirect});   // single pulse
        gap = $unsigned($random(seed)) % 4;
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic expectTrap(input string name, input logic [4:0] code, input logic setBad,
                              input logic [31:0] badVal);
        logic        slot;
        logic [31:0] pcVal;
        slot  = inDelaySlot;
        pcVal = pc;
        runInstr(name, 1'b1, `EXC_VECTOR);
        mCode = code;
        if (setBad)
            mBad = badVal;
        if (!mExl)
        begin
            mEpc = slot ? pcVal - 32'd4 : pcVal;   // delay slot returns to branch
            mBd  = slot;
        end
        mExl = 1'b1;
        checkModel(name);
    endtask

    task automatic expectEret(input string name, input logic [31:0] pcVal);
        pc     = pcVal;
        isEret = 1'b1;
        runInstr(name, 1'b1, mEpc);
        mExl = 1'b0;
        checkModel(name);
    endtask

    task automatic expectNone(input string name, input logic [31:0] pcVal);
        pc = pcVal;
        runInstr(name, 1'b0, '0);
        checkModel(name);
    endtask

    initial
    begin
        seed       = 32'hb803;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        instrValid = 1'b0;
        pc         = '0;
        hwInt      = '0;
        wbCyc      = 1'b0;
        wbStb      = 1'b0;
        wbWe       = 1'b0;
        wbAdr      = '0;
        wbDatW     = '0;
        clearFlags();
        {mIm, mExl, mIe, mBd, mSw, mCode, mEpc, mBad, mTimer} = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values and field masks
        checkModel("reset");
        busWrite(`CP0_STATUS, 32'hFFFF_FFFF);
        checkReg("status mask", `CP0_STATUS, 32'h0000_FF03);
        setStatus(32'd0);
        busWrite(`CP0_CAUSE, 32'hFFFF_FFFF);
        checkReg("cause mask", `CP0_CAUSE, 32'h0000_0300);
        setCause(32'd0);
        busWrite(`CP0_BADVADDR, 32'hDEAD_BEEF);
        checkReg("badvaddr read only", `CP0_BADVADDR, 32'd0);

        // syscall, delay slot, nested trap
        pc = 32'h1000;
        syscall = 1'b1;
        expectTrap("syscall", EXC_SYS, 1'b0, '0);
        expectEret("eret after syscall", 32'h1040);
        pc = 32'h2004;
        inDelaySlot = 1'b1;
        syscall = 1'b1;
        expectTrap("syscall in slot", EXC_SYS, 1'b0, '0);
        pc = 32'h3000;
        brk = 1'b1;
        expectTrap("nested break", EXC_BP, 1'b0, '0);   // epc kept
        expectEret("eret to branch", 32'h3010);

        // priority and badvaddr
        pc = 32'h4000;
        {reserved, overflowError, syscall, brk} = 4'hF;
        expectTrap("ri over ov", EXC_RI, 1'b0, '0);
        pc = 32'h4100;
        {overflowError, syscall, brk} = 3'b111;
        expectTrap("ov over sys", EXC_OV, 1'b0, '0);
        pc = 32'h4200;
        {syscall, brk, addressError} = 3'b111;
        expectTrap("sys over bp", EXC_SYS, 1'b0, '0);
        pc = 32'h4300;
        {brk, addressError} = 2'b11;
        expectTrap("bp over address error", EXC_BP, 1'b0, '0);
        pc = 32'h4400;
        {addressError, memWrite} = 2'b11;
        errorAddr = 32'h5003;
        expectTrap("store address error", EXC_ADES, 1'b1, 32'h5003);
        pc = 32'h4500;
        addressError = 1'b1;
        errorAddr = 32'h6001;
        expectTrap("load address error", EXC_ADEL, 1'b1, 32'h6001);
        pc = 32'h7002;
        reserved = 1'b1;
        expectTrap("misaligned fetch", EXC_ADEL, 1'b1, 32'h7002);
        expectEret("eret after priority", 32'h4600);

        // eret paths
        setEpc(32'h8000);
        setStatus(32'h0000_0002);          // exl only
        expectEret("eret to written epc", 32'h4700);
        setEpc(32'h8002);
        pc = 32'h9000;
        isEret = 1'b1;
        expectTrap("eret misaligned epc", EXC_ADEL, 1'b1, 32'h8002);
        setStatus(32'd0);

        // interrupts
        setStatus(32'h0000_0401);          // IM2 and IE
        hwInt = 5'b00001;
        pc = 32'hA000;
        expectTrap("hw interrupt", EXC_INT, 1'b0, '0);
        expectNone("interrupt blocked by exl", 32'hA100);
        hwInt = 5'b00000;
        expectEret("eret after interrupt", 32'hA200);
        setStatus(32'h0000_0400);          // IE clear
        hwInt = 5'b00001;
        expectNone("interrupt blocked by ie", 32'hA300);
        hwInt = 5'b00000;
        setStatus(32'h0000_0101);
        setCause(32'h0000_0100);           // software line 0
        pc = 32'hB000;
        expectTrap("software interrupt", EXC_INT, 1'b0, '0);
        setCause(32'd0);
        setStatus(32'd0);

        // count and compare
        busWrite(`CP0_COUNT, 32'd0);
        busWrite(`CP0_COMPARE, 32'd40);
        repeat (50) @(posedge clk);
        mTimer = 1'b1;
        checkReg("timer interrupt", `CP0_CAUSE, expCause());
        busWrite(`CP0_COMPARE, 32'hFFFF_0000);
        mTimer = 1'b0;
        checkReg("compare write clears", `CP0_CAUSE, expCause());

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/cp0Pkg.sv
source/excDetect.sv
source/cp0Timer.sv
source/cp0Regs.sv
source/excControl.sv
source/cp0Top.sv
bench/cp0Bench.sv

/* run.sh */
#!/bin/sh
# build and run the cp0 testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f src.f --top-module cp0Bench -o cp0Sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cp0Sim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation clean"
exit 0
